//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
JOBS      ?= 0
PASS_MSG  ?= Test OK

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
verilog/conv_pkg.sv
verilog/conv_apb_pkg.sv
verilog/conv_regfile.sv
verilog/conv_ctrl.sv
verilog/conv_linebuffer.sv
verilog/conv_sop.sv
verilog/conv_postproc.sv
verilog/conv_top.sv
testbench/tb_clock.sv
testbench/tb_top.sv

//--- testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
   output logic clk_o,
   output logic rst_n_o
);

   localparam int HALF_PERIOD  = 4;    // 8 ns clock
   localparam int RESET_CYCLES = 16;

   initial begin
      clk_o = 1'b0;
      forever #HALF_PERIOD clk_o = ~clk_o;
   end

   // release away from the active edge
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;
   end

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/1ns

module tb_top;
   import conv_pkg::*;
   import conv_apb_pkg::*;

   localparam int MAX_PIX     = 6 * LINE_WIDTH;
   // frames of 4, 6, 6, 6, 3 and 3 rows, up to 4 cycles a pixel when stalled
   localparam int FRAME_ROWS  = 28;
   localparam int TEST_CYCLES = 16 + 4 * LINE_WIDTH * FRAME_ROWS + 6 * 40 + 120 * 3;
   localparam int CYCLE_LIMIT = 2 * TEST_CYCLES + 1000;

   logic   clk;
   logic   rst_n;
   logic   psel;
   logic   penable;
   logic   pwrite;
   paddr_t paddr;
   pdata_t pwdata;
   pdata_t prdata;
   logic   pready;
   logic   pslverr;
   logic   pix_valid;
   pixel_t pix_data;
   logic   pix_ready;
   logic   res_valid;
   pixel_t res_data;
   logic   res_ready;

   int img [MAX_PIX];
   int wgt [KERNEL_TAPS];
   int bias_val;
   int exp_q [$];
   int pix_sent;
   int cycles = 0;

   tb_clock u_clock (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   conv_top dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .psel_i      (psel),
      .penable_i   (penable),
      .pwrite_i    (pwrite),
      .paddr_i     (paddr),
      .pwdata_i    (pwdata),
      .prdata_o    (prdata),
      .pready_o    (pready),
      .pslverr_o   (pslverr),
      .pix_valid_i (pix_valid),
      .pix_data_i  (pix_data),
      .pix_ready_o (pix_ready),
      .res_valid_o (res_valid),
      .res_data_o  (res_data),
      .res_ready_i (res_ready)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string msg);
      abort_run($sformatf("Error at %0t ns: %s", $time, msg));
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles == CYCLE_LIMIT) begin
         abort_run($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
      end
   end

   // setup cycle, then access cycle sampled mid-cycle
   task automatic apb_access(input logic wr, input paddr_t addr, input int wdata,
                             output pdata_t rdata, output logic err);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = pdata_t'(wdata);
      @(negedge clk);
      penable = 1'b1;
      #1;
      assert (pready) else report_mismatch("pready low in the access cycle");
      rdata = prdata;
      err   = pslverr;
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic write_cfg(input paddr_t addr, input int data);
      pdata_t rd;
      logic   err;
      apb_access(1'b1, addr, data, rd, err);
      assert (!err) else report_mismatch($sformatf("pslverr on write to 0x%02h", addr));
   endtask

   task automatic read_reg(input paddr_t addr, output pdata_t rd);
      logic err;
      apb_access(1'b0, addr, 0, rd, err);
      assert (!err) else report_mismatch($sformatf("pslverr on read of 0x%02h", addr));
   endtask

   task automatic load_config(input int n_rows);
      for (int i = 0; i < KERNEL_TAPS; i++) begin
         write_cfg(REG_WEIGHT_BASE + paddr_t'(4 * i), wgt[i]);
      end
      write_cfg(REG_BIAS, bias_val);
      write_cfg(REG_NROWS, n_rows);
   endtask

   function automatic int rand_pixel();
      return int'($urandom_range(0, 65535)) - 32768;
   endfunction

   // window with its bottom right corner at (r, c)
   function automatic int ref_pixel(input int r, input int c, input logic relu);
      longint acc;
      longint val;
      acc = 0;
      for (int i = 0; i < KERNEL_DIM; i++) begin
         for (int j = 0; j < KERNEL_DIM; j++) begin
            acc += longint'(img[(r + i - 2) * LINE_WIDTH + c + j - 2]) *
                   longint'(wgt[i * KERNEL_DIM + j]);
         end
      end
      val = (acc >>> QF) + longint'(bias_val);
      if (val > longint'(PIX_MAX)) val = longint'(PIX_MAX);
      if (val < longint'(PIX_MIN)) val = longint'(PIX_MIN);
      if (relu && val < 0) val = 0;
      return int'(val);
   endfunction

   task automatic build_expected(input int n_rows, input logic relu);
      exp_q.delete();
      for (int r = KERNEL_DIM - 1; r < n_rows; r++) begin
         for (int c = KERNEL_DIM - 1; c < LINE_WIDTH; c++) begin
            exp_q.push_back(ref_pixel(r, c, relu));
         end
      end
   endtask

   task automatic run_frame(input int n_rows, input logic relu, input logic stall);
      pdata_t rd;
      int     npix;
      int     got;
      int     polls;
      logic   held;
      pixel_t held_val;
      build_expected(n_rows, relu);
      npix     = LINE_WIDTH * n_rows;
      got      = 0;
      held     = 1'b0;
      held_val = '0;
      pix_sent = 0;
      write_cfg(REG_CTRL, (int'(relu) << CTRL_RELU_BIT) | (1 << CTRL_START_BIT));
      read_reg(REG_CTRL, rd);
      assert (rd[CTRL_START_BIT] == 1'b0 && rd[CTRL_RELU_BIT] == relu)
         else report_mismatch($sformatf("CTRL reads 0x%08h", rd));
      read_reg(REG_STATUS, rd);
      assert (rd[STAT_BUSY_BIT] && !rd[STAT_DONE_BIT])
         else report_mismatch($sformatf("STATUS reads 0x%08h after start", rd));
      while (got < exp_q.size()) begin
         @(negedge clk);
         pix_valid = (pix_sent < npix) && (!stall || $urandom_range(0, 3) != 0);
         if (pix_sent < npix) pix_data = pixel_t'(img[pix_sent]);
         res_ready = !stall || $urandom_range(0, 2) != 0;
         #1;   // both handshakes settle before the next rising edge
         if (pix_valid && pix_ready) pix_sent++;
         if (res_valid) begin
            assert (!held || res_data == held_val)
               else report_mismatch("result changed while stalled");
            if (res_ready) begin
               assert (int'(res_data) == exp_q[got])
                  else report_mismatch($sformatf("result %0d is %0d, expected %0d",
                                                 got, res_data, exp_q[got]));
               got++;
               held = 1'b0;
            end else begin
               held     = 1'b1;
               held_val = res_data;
            end
         end else begin
            assert (!held) else report_mismatch("result withdrawn before it was accepted");
         end
      end
      @(negedge clk);
      pix_valid = 1'b0;
      res_ready = 1'b0;
      polls     = 0;
      do begin
         read_reg(REG_STATUS, rd);
         polls++;
      end while (!rd[STAT_DONE_BIT] && polls < 8);
      assert (rd[STAT_DONE_BIT]) else abort_run("done was never set after the last result");
      assert (!rd[STAT_BUSY_BIT]) else report_mismatch("busy still set after the frame");
      assert (pix_sent == npix) else report_mismatch("not every pixel was accepted");
      assert (!res_valid) else report_mismatch("extra result after the frame");
   endtask

   task automatic test_apb();
      pdata_t rd;
      logic   err;
      assert (!pix_ready && !res_valid && !pslverr)
         else report_mismatch("outputs not idle after reset");
      for (int i = 0; i < KERNEL_TAPS; i++) wgt[i] = i * 37 - 150;
      bias_val = -1234;
      load_config(5);
      for (int i = 0; i < KERNEL_TAPS; i++) begin
         read_reg(REG_WEIGHT_BASE + paddr_t'(4 * i), rd);
         assert (rd == pdata_t'(wgt[i]))
            else report_mismatch($sformatf("weight %0d reads 0x%08h", i, rd));
      end
      read_reg(REG_BIAS, rd);
      assert (rd == pdata_t'(bias_val)) else report_mismatch("bias readback");
      read_reg(REG_NROWS, rd);
      assert (rd == 32'd5) else report_mismatch("row count readback");
      read_reg(REG_STATUS, rd);
      assert (rd == 32'd0) else report_mismatch("status not clear after reset");
      apb_access(1'b0, 8'h34, 0, rd, err);   // past the last weight
      assert (err) else report_mismatch("no pslverr on read of 0x34");
      apb_access(1'b1, 8'h40, 5, rd, err);
      assert (err) else report_mismatch("no pslverr on write to 0x40");
      apb_access(1'b0, 8'h12, 0, rd, err);   // unaligned inside the weights
      assert (err) else report_mismatch("no pslverr on read of 0x12");
   endtask

   task automatic test_identity();
      foreach (wgt[i]) wgt[i] = 0;
      wgt[4]   = 256;
      bias_val = 0;
      for (int i = 0; i < 4 * LINE_WIDTH; i++) img[i] = rand_pixel();
      load_config(4);
      run_frame(4, 1'b0, 1'b0);
   endtask

   task automatic test_random();
      for (int i = 0; i < KERNEL_TAPS; i++) wgt[i] = int'($urandom_range(64, 255));
      bias_val = int'($urandom_range(0, 200)) - 100;
      for (int i = 0; i < MAX_PIX; i++) img[i] = rand_pixel();
      // corner blocks push the sum past both bounds
      for (int r = 0; r < KERNEL_DIM; r++) begin
         for (int c = 0; c < KERNEL_DIM; c++) begin
            img[r * LINE_WIDTH + c]           = 32767;
            img[(r + 3) * LINE_WIDTH + c + 5] = -32768;
         end
      end
      load_config(6);
      run_frame(6, 1'b0, 1'b0);
   endtask

   // same frame as test_random, with gaps on both streams
   task automatic test_stall();
      run_frame(6, 1'b0, 1'b1);
   endtask

   task automatic test_busy_write();
      pdata_t rd;
      logic   err;
      pix_sent = 0;
      fork
         run_frame(6, 1'b0, 1'b0);
         begin
            wait (pix_sent >= 10);
            apb_access(1'b1, REG_WEIGHT_BASE + paddr_t'(16), 1000, rd, err);
            assert (err) else report_mismatch("no pslverr on weight write while busy");
         end
      join
      read_reg(REG_WEIGHT_BASE + paddr_t'(16), rd);
      assert (rd == pdata_t'(wgt[4])) else report_mismatch("weight changed while busy");
   endtask

   task automatic test_relu();
      foreach (wgt[i]) wgt[i] = 0;
      wgt[4]   = -256;   // every result negative
      bias_val = 0;
      for (int i = 0; i < 3 * LINE_WIDTH; i++) img[i] = int'($urandom_range(1, 1000));
      load_config(3);
      run_frame(3, 1'b0, 1'b0);
      run_frame(3, 1'b1, 1'b0);
   endtask

   initial begin
      void'($urandom(32'h5103));
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      pix_valid = 1'b0;
      pix_data  = '0;
      res_ready = 1'b0;
      wait (rst_n === 1'b1);
      @(negedge clk);
      test_apb();
      test_identity();
      test_random();
      test_stall();
      test_busy_write();
      test_relu();
      $display("Test OK");
      $finish;
   end

endmodule

//--- verilog/conv_apb_pkg.sv
package conv_apb_pkg;

   localparam int PADDR_W = 8;
   localparam int PDATA_W = 32;

   typedef logic [PADDR_W-1:0] paddr_t;
   typedef logic [PDATA_W-1:0] pdata_t;

   // register map
   localparam paddr_t REG_CTRL        = 8'h00;
   localparam paddr_t REG_STATUS      = 8'h04;
   localparam paddr_t REG_NROWS       = 8'h08;
   localparam paddr_t REG_BIAS        = 8'h0C;
   localparam paddr_t REG_WEIGHT_BASE = 8'h10;   // nine weights, one word each

   // CTRL bits
   localparam int CTRL_START_BIT = 0;
   localparam int CTRL_RELU_BIT  = 1;

   // STATUS bits
   localparam int STAT_BUSY_BIT = 0;
   localparam int STAT_DONE_BIT = 1;

endpackage

//--- verilog/conv_ctrl.sv
`timescale 1ns/1ns

module conv_ctrl (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           start_i,
   input  conv_pkg::row_t n_rows_i,
   input  logic           pix_valid_i,
   output logic           pix_ready_o,
   input  logic           res_valid_i,
   input  logic           res_ready_i,
   input  logic           pipe_advance_i,
   output logic           frame_start_o,
   output logic           pix_push_o,
   output logic           busy_o,
   output logic           done_o
);
   import conv_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      RUN,    // accepting pixels
      DRAIN   // all pixels in, waiting for the last results
   } ctrl_state_t;

   ctrl_state_t state_q;
   frame_cnt_t  pix_cnt_q;
   frame_cnt_t  res_cnt_q;
   frame_cnt_t  pix_total;
   frame_cnt_t  res_total;
   logic        res_fire;

   // only fully in-bounds windows give a result
   assign pix_total = frame_cnt_t'(n_rows_i * LINE_WIDTH);
   assign res_total = frame_cnt_t'((n_rows_i - (KERNEL_DIM - 1)) *
                                   (LINE_WIDTH - (KERNEL_DIM - 1)));

   assign pix_ready_o   = (state_q == RUN) & pipe_advance_i;
   assign pix_push_o    = pix_valid_i & pix_ready_o;
   assign frame_start_o = (state_q == IDLE) & start_i;
   assign res_fire      = res_valid_i & res_ready_i;
   assign busy_o        = (state_q != IDLE);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q   <= IDLE;
         pix_cnt_q <= '0;
         res_cnt_q <= '0;
         done_o    <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (start_i) begin
                  state_q   <= RUN;
                  pix_cnt_q <= '0;
                  res_cnt_q <= '0;
                  done_o    <= 1'b0;   // sticky until the next start
               end
            end
            RUN: begin
               if (pix_push_o) begin
                  pix_cnt_q <= pix_cnt_q + 1'b1;
                  if (pix_cnt_q == pix_total - 1'b1) state_q <= DRAIN;
               end
               if (res_fire) res_cnt_q <= res_cnt_q + 1'b1;
            end
            DRAIN: begin
               if (res_fire) begin
                  res_cnt_q <= res_cnt_q + 1'b1;
                  if (res_cnt_q == res_total - 1'b1) begin
                     state_q <= IDLE;
                     done_o  <= 1'b1;
                  end
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

endmodule

//--- verilog/conv_linebuffer.sv
`timescale 1ns/1ns

module conv_linebuffer (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             frame_start_i,
   input  logic             pix_push_i,
   input  logic             pipe_advance_i,
   input  conv_pkg::pixel_t pix_data_i,
   output logic             win_valid_o,
   output conv_pkg::pixel_t window_o [conv_pkg::KERNEL_TAPS]
);
   import conv_pkg::*;

   pixel_t line1_q [LINE_WIDTH];   // previous line
   pixel_t line2_q [LINE_WIDTH];   // line before that
   pixel_t col_new [KERNEL_DIM];   // column entering the window, top first
   col_t   col_q;
   row_t   row_q;
   logic   win_done;

   assign col_new[0] = line2_q[col_q];
   assign col_new[1] = line1_q[col_q];
   assign col_new[2] = pix_data_i;

   // pushed pixel is the bottom right corner of an in-bounds window
   assign win_done = (col_q >= col_t'(KERNEL_DIM - 1)) &&
                     (row_q >= row_t'(KERNEL_DIM - 1));

   // position in the frame
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         col_q       <= '0;
         row_q       <= '0;
         win_valid_o <= 1'b0;
      end else if (frame_start_i) begin
         col_q       <= '0;
         row_q       <= '0;
         win_valid_o <= 1'b0;
      end else begin
         if (pix_push_i) begin
            if (col_q == col_t'(LINE_WIDTH - 1)) begin
               col_q <= '0;
               row_q <= row_q + 1'b1;
            end else begin
               col_q <= col_q + 1'b1;
            end
         end
         if (pipe_advance_i) win_valid_o <= pix_push_i & win_done;   // held on a stall
      end
   end

   // line memories and window shift
   always_ff @(posedge clk) begin
      if (pix_push_i) begin
         line2_q[col_q] <= line1_q[col_q];
         line1_q[col_q] <= pix_data_i;
         for (int r = 0; r < KERNEL_DIM; r++) begin
            for (int k = 0; k < KERNEL_DIM - 1; k++) begin
               window_o[r*KERNEL_DIM + k] <= window_o[r*KERNEL_DIM + k + 1];
            end
            window_o[r*KERNEL_DIM + KERNEL_DIM - 1] <= col_new[r];   // newest on the right
         end
      end
   end

endmodule

//--- verilog/conv_pkg.sv
package conv_pkg;

   // data path
   typedef logic signed [15:0] pixel_t;
   typedef logic signed [15:0] weight_t;
   typedef logic signed [31:0] prod_t;   // pixel times weight
   typedef logic signed [35:0] acc_t;    // sum of nine products plus headroom

   // kernel and line geometry
   localparam int KERNEL_DIM  = 3;
   localparam int KERNEL_TAPS = KERNEL_DIM * KERNEL_DIM;
   localparam int LINE_WIDTH  = 8;

   typedef logic [2:0]  col_t;       // column inside a line
   typedef logic [7:0]  row_t;       // row count of a frame
   typedef logic [10:0] frame_cnt_t; // pixels or results in one frame

   // fixed point, fraction bits dropped from the sum
   localparam int QF = 8;

   // saturation bounds of the output pixel
   localparam pixel_t PIX_MAX = pixel_t'(16'h7fff);
   localparam pixel_t PIX_MIN = pixel_t'(16'h8000);

endpackage

//--- verilog/conv_postproc.sv
`timescale 1ns/1ns

module conv_postproc (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             sum_valid_i,
   input  conv_pkg::acc_t   sum_i,
   input  conv_pkg::pixel_t bias_i,
   input  logic             relu_en_i,
   input  logic             res_ready_i,
   output logic             res_valid_o,
   output conv_pkg::pixel_t res_data_o,
   output logic             pipe_advance_o
);
   import conv_pkg::*;

   acc_t   scaled;
   acc_t   biased;
   pixel_t sat;
   pixel_t result;

   always_comb begin
      scaled = sum_i >>> QF;               // drop the fraction bits
      biased = scaled + acc_t'(bias_i);
      if (biased > acc_t'(PIX_MAX)) begin
         sat = PIX_MAX;
      end else if (biased < acc_t'(PIX_MIN)) begin
         sat = PIX_MIN;
      end else begin
         sat = pixel_t'(biased);
      end
      result = (relu_en_i && sat < 0) ? '0 : sat;   // rectifier
   end

   // stall while a result waits for the sink
   assign pipe_advance_o = ~res_valid_o | res_ready_i;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         res_valid_o <= 1'b0;
      end else if (pipe_advance_o) begin
         res_valid_o <= sum_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (pipe_advance_o && sum_valid_i) res_data_o <= result;
   end

endmodule

//--- verilog/conv_regfile.sv
`timescale 1ns/1ns

module conv_regfile (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 psel_i,
   input  logic                 penable_i,
   input  logic                 pwrite_i,
   input  conv_apb_pkg::paddr_t paddr_i,
   input  conv_apb_pkg::pdata_t pwdata_i,
   output conv_apb_pkg::pdata_t prdata_o,
   output logic                 pready_o,
   output logic                 pslverr_o,
   input  logic                 busy_i,
   input  logic                 done_i,
   output logic                 start_o,
   output logic                 relu_en_o,
   output conv_pkg::row_t       n_rows_o,
   output conv_pkg::pixel_t     bias_o,
   output conv_pkg::weight_t    weights_o [conv_pkg::KERNEL_TAPS]
);
   import conv_pkg::*;
   import conv_apb_pkg::*;

   logic   access;
   logic   wr_access;
   logic   is_weight;
   logic   is_cfg;
   logic   mapped;
   logic   cfg_we;
   paddr_t w_off;
   logic   [3:0] w_idx;

   assign access    = psel_i & penable_i;
   assign wr_access = access & pwrite_i;

   // weight window 0x10..0x30, word aligned
   assign w_off     = paddr_i - REG_WEIGHT_BASE;
   assign w_idx     = w_off[5:2];
   assign is_weight = (paddr_i >= REG_WEIGHT_BASE) &&
                      (paddr_i <= REG_WEIGHT_BASE + paddr_t'(4 * (KERNEL_TAPS - 1))) &&
                      (paddr_i[1:0] == 2'b00);

   assign is_cfg = (paddr_i == REG_NROWS) || (paddr_i == REG_BIAS) || is_weight;
   assign mapped = (paddr_i == REG_CTRL) || (paddr_i == REG_STATUS) || is_cfg;
   assign cfg_we = wr_access & is_cfg & ~busy_i;   // frozen while a frame runs

   assign pready_o  = 1'b1;   // zero wait states
   assign pslverr_o = access & (~mapped | (pwrite_i & is_cfg & busy_i));

   // start pulse lasts only the access cycle
   assign start_o = wr_access & (paddr_i == REG_CTRL) & pwdata_i[CTRL_START_BIT];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         relu_en_o <= 1'b0;
         n_rows_o  <= row_t'(KERNEL_DIM);
         bias_o    <= '0;
         for (int i = 0; i < KERNEL_TAPS; i++) begin
            weights_o[i] <= '0;
         end
      end else begin
         if (wr_access && paddr_i == REG_CTRL) begin
            relu_en_o <= pwdata_i[CTRL_RELU_BIT];
         end
         if (cfg_we) begin
            if (paddr_i == REG_NROWS) n_rows_o <= row_t'(pwdata_i);
            if (paddr_i == REG_BIAS)  bias_o   <= pixel_t'(pwdata_i[15:0]);
            if (is_weight)            weights_o[w_idx] <= weight_t'(pwdata_i[15:0]);
         end
      end
   end

   // read mux, start bit always reads 0
   always_comb begin
      prdata_o = '0;
      if (paddr_i == REG_CTRL) begin
         prdata_o[CTRL_RELU_BIT] = relu_en_o;
      end else if (paddr_i == REG_STATUS) begin
         prdata_o[STAT_BUSY_BIT] = busy_i;
         prdata_o[STAT_DONE_BIT] = done_i;
      end else if (paddr_i == REG_NROWS) begin
         prdata_o = pdata_t'(n_rows_o);
      end else if (paddr_i == REG_BIAS) begin
         prdata_o = pdata_t'(bias_o);              // sign extended
      end else if (is_weight) begin
         prdata_o = pdata_t'(weights_o[w_idx]);
      end
   end

endmodule

//--- verilog/conv_sop.sv
`timescale 1ns/1ns

module conv_sop (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              pipe_advance_i,
   input  logic              win_valid_i,
   input  conv_pkg::pixel_t  window_i  [conv_pkg::KERNEL_TAPS],
   input  conv_pkg::weight_t weights_i [conv_pkg::KERNEL_TAPS],
   output logic              sum_valid_o,
   output conv_pkg::acc_t    sum_o
);
   import conv_pkg::*;

   prod_t prod_q [KERNEL_TAPS];
   logic  prod_valid_q;
   acc_t  sum_d;

   // sum of the registered products
   always_comb begin
      sum_d = '0;
      for (int i = 0; i < KERNEL_TAPS; i++) begin
         sum_d = sum_d + acc_t'(prod_q[i]);
      end
   end

   // valid bits of both stages
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         prod_valid_q <= 1'b0;
         sum_valid_o  <= 1'b0;
      end else if (pipe_advance_i) begin
         prod_valid_q <= win_valid_i;
         sum_valid_o  <= prod_valid_q;
      end
   end

   // stage one, signed multiplies
   always_ff @(posedge clk) begin
      if (pipe_advance_i && win_valid_i) begin
         for (int i = 0; i < KERNEL_TAPS; i++) begin
            prod_q[i] <= window_i[i] * weights_i[i];
         end
      end
   end

   // stage two
   always_ff @(posedge clk) begin
      if (pipe_advance_i && prod_valid_q) sum_o <= sum_d;
   end

endmodule

//--- verilog/conv_top.sv
`timescale 1ns/1ns

module conv_top (
   input  logic                 clk,
   input  logic                 rst_n,
   // APB configuration port
   input  logic                 psel_i,
   input  logic                 penable_i,
   input  logic                 pwrite_i,
   input  conv_apb_pkg::paddr_t paddr_i,
   input  conv_apb_pkg::pdata_t pwdata_i,
   output conv_apb_pkg::pdata_t prdata_o,
   output logic                 pready_o,
   output logic                 pslverr_o,
   // pixel stream in
   input  logic                 pix_valid_i,
   input  conv_pkg::pixel_t     pix_data_i,
   output logic                 pix_ready_o,
   // result stream out
   output logic                 res_valid_o,
   output conv_pkg::pixel_t     res_data_o,
   input  logic                 res_ready_i
);
   import conv_pkg::*;

   logic    start;
   logic    relu_en;
   row_t    n_rows;
   pixel_t  bias;
   weight_t weights [KERNEL_TAPS];
   logic    busy;
   logic    done;
   logic    frame_start;
   logic    pix_push;
   logic    win_valid;
   pixel_t  window [KERNEL_TAPS];
   logic    sum_valid;
   acc_t    sum;
   logic    pipe_advance;   // low while a result is held

   conv_regfile u_regfile (
      .clk       (clk),
      .rst_n     (rst_n),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o),
      .busy_i    (busy),
      .done_i    (done),
      .start_o   (start),
      .relu_en_o (relu_en),
      .n_rows_o  (n_rows),
      .bias_o    (bias),
      .weights_o (weights)
   );

   conv_ctrl u_ctrl (
      .clk            (clk),
      .rst_n          (rst_n),
      .start_i        (start),
      .n_rows_i       (n_rows),
      .pix_valid_i    (pix_valid_i),
      .pix_ready_o    (pix_ready_o),
      .res_valid_i    (res_valid_o),
      .res_ready_i    (res_ready_i),
      .pipe_advance_i (pipe_advance),
      .frame_start_o  (frame_start),
      .pix_push_o     (pix_push),
      .busy_o         (busy),
      .done_o         (done)
   );

   conv_linebuffer u_linebuffer (
      .clk            (clk),
      .rst_n          (rst_n),
      .frame_start_i  (frame_start),
      .pix_push_i     (pix_push),
      .pipe_advance_i (pipe_advance),
      .pix_data_i     (pix_data_i),
      .win_valid_o    (win_valid),
      .window_o       (window)
   );

   conv_sop u_sop (
      .clk            (clk),
      .rst_n          (rst_n),
      .pipe_advance_i (pipe_advance),
      .win_valid_i    (win_valid),
      .window_i       (window),
      .weights_i      (weights),
      .sum_valid_o    (sum_valid),
      .sum_o          (sum)
   );

   conv_postproc u_postproc (
      .clk            (clk),
      .rst_n          (rst_n),
      .sum_valid_i    (sum_valid),
      .sum_i          (sum),
      .bias_i         (bias),
      .relu_en_i      (relu_en),
      .res_ready_i    (res_ready_i),
      .res_valid_o    (res_valid_o),
      .res_data_o     (res_data_o),
      .pipe_advance_o (pipe_advance)
   );

endmodule
